// ==== Bender.yml ====
# APB3 slave with 512-word on-chip SRAM
package:
  name: apb_sram

dependencies: {}

sources:
  # Synthesizable design, package first
  - files:
      - hw/apbSramPkg.sv
      - hw/sramReqIf.sv
      - hw/apbSlavePort.sv
      - hw/sramArray.sv
      - hw/readDataHold.sv
      - hw/apbSramTop.sv

  # Testbench, top module apbSramTb
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/apbSramTb.sv

// ==== hw/apbSlavePort.sv ====
// APB slave decode and wait states
`timescale 1ns/1ps
`default_nettype none

module apbSlavePort
   import apbSramPkg::*;
(
   input  logic     PCLK,
   input  logic     PRESETN,

   // APB request side
   input  logic     psel,
   input  logic     penable,
   input  logic     pwrite,
   input  apbAddr_t paddr,
   input  apbData_t pwdata,

   // Transfer completion
   output logic     pready,

   // Towards memory and read data hold
   sramReqIf.port   req
);

   // ------------------------------------------------------------------
   // Phase decode
   // ------------------------------------------------------------------

   logic writeAccess;
   logic readSetup;
   logic readAccess;
   logic readyReg;

   // Write happens at the end of the first access cycle
   assign writeAccess = psel & penable & pwrite;

   // Setup phase of a read, memory captures the address here
   assign readSetup = psel & ~penable & ~pwrite;

   // Both cycles of a read access phase
   assign readAccess = psel & penable & ~pwrite;

   // ------------------------------------------------------------------
   // Request outputs
   // ------------------------------------------------------------------

   assign req.writeEn    = writeAccess;
   assign req.readEn     = readSetup;
   assign req.readAccess = readAccess;

   // Sequential word addressing, upper PADDR bits alias
   assign req.addr = paddr[sramAddrWidth-1:0];

   assign req.writeData = pwdata;

   // ------------------------------------------------------------------
   // Read wait state
   // ------------------------------------------------------------------

   // One low cycle after a read setup, while the memory fetches the word.
   // Writes and idle cycles leave PREADY high.
   always_ff @(posedge PCLK or negedge PRESETN) begin
      if (!PRESETN) begin
         readyReg <= 1'b1;
      end
      else if (readSetup && readyReg) begin
         readyReg <= 1'b0;
      end
      else begin
         readyReg <= 1'b1;
      end
   end

   assign pready = readyReg;

endmodule

`default_nettype wire

// ==== hw/apbSramPkg.sv ====
// APB SRAM shared definitions
`default_nettype none

package apbSramPkg;

   // ------------------------------------------------------------------
   // APB bus widths
   // ------------------------------------------------------------------

   // Data bus, fixed at the 32-bit configuration
   localparam int apbDataWidth = 32;

   // Full PADDR width as seen on the bus
   localparam int apbAddrWidth = 20;

   // ------------------------------------------------------------------
   // Memory geometry
   // ------------------------------------------------------------------

   // Words in the on-chip array
   localparam int sramDepth = 512;

   // Word index width, sequential addressing
   localparam int sramAddrWidth = $clog2(sramDepth);

   // ------------------------------------------------------------------
   // Vector types
   // ------------------------------------------------------------------

   // One data word on PWDATA, PRDATA or in the array
   typedef logic [apbDataWidth-1:0] apbData_t;

   // Raw bus address
   typedef logic [apbAddrWidth-1:0] apbAddr_t;

   // Word index into the array
   typedef logic [sramAddrWidth-1:0] sramAddr_t;

endpackage

`default_nettype wire

// ==== hw/apbSramTop.sv ====
// APB3 SRAM slave top level
`timescale 1ns/1ps
`default_nettype none

module apbSramTop
   import apbSramPkg::*;
(
   input  logic     PCLK,
   input  logic     PRESETN,

   // APB3 request
   input  logic     PSEL,
   input  logic     PENABLE,
   input  logic     PWRITE,
   input  apbAddr_t PADDR,
   input  apbData_t PWDATA,

   // APB3 response
   output apbData_t PRDATA,
   output logic     PREADY,
   output logic     PSLVERR
);

   // ------------------------------------------------------------------
   // Internal connections
   // ------------------------------------------------------------------

   // Decoder to memory and hold logic
   sramReqIf reqBus ();

   // Memory read port to PRDATA select
   apbData_t sramReadData;

   // ------------------------------------------------------------------
   // APB decode
   // ------------------------------------------------------------------

   apbSlavePort slavePort (
      .PCLK    (PCLK),
      .PRESETN (PRESETN),
      .psel    (PSEL),
      .penable (PENABLE),
      .pwrite  (PWRITE),
      .paddr   (PADDR),
      .pwdata  (PWDATA),
      .pready  (PREADY),
      .req     (reqBus.port)
   );

   // ------------------------------------------------------------------
   // Memory
   // ------------------------------------------------------------------

   sramArray sramMem (
      .PCLK     (PCLK),
      .req      (reqBus.sram),
      .readData (sramReadData)
   );

   // ------------------------------------------------------------------
   // Read data
   // ------------------------------------------------------------------

   readDataHold dataHold (
      .PCLK     (PCLK),
      .PRESETN  (PRESETN),
      .req      (reqBus.hold),
      .readData (sramReadData),
      .prdata   (PRDATA)
   );

   // No error responses from this slave
   assign PSLVERR = 1'b0;

endmodule

`default_nettype wire

// ==== hw/readDataHold.sv ====
// PRDATA select and hold
`timescale 1ns/1ps
`default_nettype none

module readDataHold
   import apbSramPkg::*;
(
   input  logic     PCLK,
   input  logic     PRESETN,

   // Read access phase level from the decoder
   sramReqIf.hold   req,

   // Word from the memory read port
   input  apbData_t readData,

   // Bus read data
   output apbData_t prdata
);

   // ------------------------------------------------------------------
   // Hold register
   // ------------------------------------------------------------------

   // Last value shown on the bus
   apbData_t holdReg;

   // Reloads from the bus every cycle so PRDATA never drifts
   always_ff @(posedge PCLK or negedge PRESETN) begin
      if (!PRESETN) begin
         holdReg <= '0;
      end
      else begin
         holdReg <= prdata;
      end
   end

   // ------------------------------------------------------------------
   // Output select
   // ------------------------------------------------------------------

   // Memory word during a read access phase, held word otherwise
   always_comb begin
      if (req.readAccess) begin
         prdata = readData;
      end
      else begin
         prdata = holdReg;
      end
   end

endmodule

`default_nettype wire

// ==== hw/sramArray.sv ====
// Synchronous SRAM word array
`timescale 1ns/1ps
`default_nettype none

module sramArray
   import apbSramPkg::*;
(
   input  logic     PCLK,

   // Strobes, index and write word from the decoder
   sramReqIf.sram   req,

   // Registered read word
   output apbData_t readData
);

   // ------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------

   // Single-port array, maps onto a block RAM
   apbData_t memWords [sramDepth];

   // Read port register
   apbData_t readWord;

   // ------------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------------

   // Word written on the edge ending the first access cycle
   always_ff @(posedge PCLK) begin
      if (req.writeEn) begin
         memWords[req.addr] <= req.writeData;
      end
   end

   // ------------------------------------------------------------------
   // Read port
   // ------------------------------------------------------------------

   // Address sampled at the end of read setup.
   // Data then stays put until the next read setup.
   always_ff @(posedge PCLK) begin
      if (req.readEn) begin
         readWord <= memWords[req.addr];
      end
   end

   assign readData = readWord;

endmodule

`default_nettype wire

// ==== hw/sramReqIf.sv ====
// SRAM request bundle
`timescale 1ns/1ps
`default_nettype none

interface sramReqIf
   import apbSramPkg::*;
();

   // Strobes towards the memory
   logic      writeEn;
   logic      readEn;

   // Word index and write payload
   sramAddr_t addr;
   apbData_t  writeData;

   // High for the whole read access phase
   logic      readAccess;

   // APB decoder side
   modport port (
      output writeEn,
      output readEn,
      output addr,
      output writeData,
      output readAccess
   );

   // Memory side
   modport sram (
      input writeEn,
      input readEn,
      input addr,
      input writeData
   );

   // PRDATA hold side
   modport hold (
      input readAccess
   );

endinterface

`default_nettype wire

// ==== sim/apbSramTasks.svh ====
// APB bus tasks and value check
`ifndef APB_SRAM_TASKS_SVH
`define APB_SRAM_TASKS_SVH

// ----------------------------------------------------------------------
// Value check
// ----------------------------------------------------------------------

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
   if (actual !== expected) begin
      $display("FAIL at %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopped at first mismatch");
   end
endtask

// ----------------------------------------------------------------------
// APB transfers
// ----------------------------------------------------------------------

// Setup, access until PREADY, then back to idle
task automatic writeWord(input apbAddr_t addr, input apbData_t data);
   @(posedge PCLK);
   PSEL    <= 1'b1;
   PENABLE <= 1'b0;
   PWRITE  <= 1'b1;
   PADDR   <= addr;
   PWDATA  <= data;
   @(posedge PCLK);
   PENABLE <= 1'b1;
   @(negedge PCLK);
   while (PREADY !== 1'b1) begin
      @(negedge PCLK);
   end
   @(posedge PCLK);
   PSEL    <= 1'b0;
   PENABLE <= 1'b0;
   shadowMem[addr % sramDepth] = data;
   writtenIdx.push_back(sramAddr_t'(addr % sramDepth));
endtask

// Read data is checked by the comparing process
task automatic readWord(input apbAddr_t addr);
   @(posedge PCLK);
   PSEL    <= 1'b1;
   PENABLE <= 1'b0;
   PWRITE  <= 1'b0;
   PADDR   <= addr;
   @(posedge PCLK);
   PENABLE <= 1'b1;
   @(negedge PCLK);
   while (PREADY !== 1'b1) begin
      @(negedge PCLK);
   end
   @(posedge PCLK);
   PSEL    <= 1'b0;
   PENABLE <= 1'b0;
endtask

task automatic idleCycles(input int count);
   repeat (count) @(posedge PCLK);
endtask

`endif

// ==== sim/apbSramTb.sv ====
// APB SRAM slave testbench
`timescale 1ns/1ps
`default_nettype none

module apbSramTb
   import apbSramPkg::*;
();

   // ------------------------------------------------------------------
   // Run constants
   // ------------------------------------------------------------------

   localparam int clkPeriod     = 10;
   localparam int randomSeed    = 74727;
   localparam int directedCount = 12;
   localparam int randomCount   = 300;
   localparam int numTransfers  = directedCount + randomCount;
   localparam int timeoutCycles = numTransfers * 4 + 50;

   // ------------------------------------------------------------------
   // DUT signals
   // ------------------------------------------------------------------

   logic     PCLK;
   logic     PRESETN;
   logic     PSEL;
   logic     PENABLE;
   logic     PWRITE;
   apbAddr_t PADDR;
   apbData_t PWDATA;
   apbData_t PRDATA;
   logic     PREADY;
   logic     PSLVERR;

   // Reference model state
   apbData_t  shadowMem [sramDepth];
   sramAddr_t writtenIdx [$];
   apbData_t  lastReadWord = '0;
   int        accessCycles = 0;

   `include "apbSramTasks.svh"

   apbSramTop dut (
      .PCLK    (PCLK),
      .PRESETN (PRESETN),
      .PSEL    (PSEL),
      .PENABLE (PENABLE),
      .PWRITE  (PWRITE),
      .PADDR   (PADDR),
      .PWDATA  (PWDATA),
      .PRDATA  (PRDATA),
      .PREADY  (PREADY),
      .PSLVERR (PSLVERR)
   );

   initial begin
      PCLK = 1'b0;
      forever #(clkPeriod / 2) PCLK = ~PCLK;
   end

   // Expected read word, sequential index with upper PADDR bits aliased
   function automatic apbData_t expectedRead(input apbAddr_t addr);
      return shadowMem[addr % sramDepth];
   endfunction

   // ------------------------------------------------------------------
   // Comparing process, mid-cycle when everything has settled
   // ------------------------------------------------------------------

   always @(negedge PCLK) begin
      if (PRESETN === 1'b1) begin
         checkValue("PSLVERR", PSLVERR, 1'b0);
         if (PSEL && PENABLE && !PWRITE) begin
            // One wait state, then completion
            if (accessCycles == 0) begin
               checkValue("PREADY", PREADY, 1'b0);
            end
            else begin
               checkValue("PREADY", PREADY, 1'b1);
            end
            checkValue("PRDATA", PRDATA, expectedRead(PADDR));
            if (PREADY) begin
               lastReadWord = expectedRead(PADDR);
               accessCycles = 0;
            end
            else begin
               accessCycles++;
            end
         end
         else begin
            // Idle, setup and write cycles keep the last read word
            checkValue("PREADY", PREADY, 1'b1);
            checkValue("PRDATA", PRDATA, lastReadWord);
         end
      end
   end

   // Watchdog
   initial begin
      #(timeoutCycles * clkPeriod);
      $display("Watchdog expired after %0d cycles, a transfer never completed",
               timeoutCycles);
      $display("Test FAILED");
      $fatal(1, "Run stopped by watchdog");
   end

   task automatic randomTransfers(input int count);
      apbAddr_t  addr;
      sramAddr_t idx;
      for (int i = 0; i < count; i++) begin
         if (writtenIdx.size() == 0 || $urandom_range(1, 0) == 1) begin
            addr = apbAddr_t'($urandom);
            writeWord(addr, apbData_t'($urandom));
         end
         else begin
            // Only words already written, random alias bits on top
            idx = writtenIdx[$urandom_range(writtenIdx.size() - 1, 0)];
            addr = apbAddr_t'($urandom);
            addr[sramAddrWidth-1:0] = idx;
            readWord(addr);
         end
      end
   endtask

   // ------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------

   initial begin
      void'($urandom(randomSeed));
      PRESETN = 1'b0;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
      PADDR   = '0;
      PWDATA  = '0;
      repeat (3) @(posedge PCLK);
      PRESETN <= 1'b1;

      // Reset values before any transfer
      @(negedge PCLK);
      checkValue("PREADY", PREADY, 1'b1);
      checkValue("PRDATA", PRDATA, 32'h0);
      idleCycles(2);

      // Write then read back, bits above 8 alias
      writeWord(20'h00005, 32'hA5A5_0001);
      readWord(20'h00005);
      writeWord(20'h00205, 32'h5A5A_0002);
      readWord(20'h00005);
      readWord(20'hFFE05);
      writeWord(20'h001FF, 32'hDEAD_BEEF);
      writeWord(20'h00000, 32'h1234_5678);
      readWord(20'h001FF);
      readWord(20'h80000);

      // Held PRDATA through idle and writes
      idleCycles(5);
      writeWord(20'h00010, 32'h0F0F_0F0F);
      writeWord(20'h00011, 32'hF0F0_F0F0);
      readWord(20'h00010);

      randomTransfers(randomCount);
      idleCycles(2);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+sim
hw/apbSramPkg.sv
hw/sramReqIf.sv
hw/apbSlavePort.sv
hw/sramArray.sv
hw/readDataHold.sv
hw/apbSramTop.sv
sim/apbSramTb.sv
